//--- alpha_defs.svh
////////////////////
// alpha opcode, function and pal codes for the front end
// only the integer subset is decoded, the fp groups stay illegal
// fetch starts at RESET_PC and runs sequentially
////////////////////
`ifndef ALPHA_DEFS_SVH
`define ALPHA_DEFS_SVH

`define TRUE  1'b1
`define FALSE 1'b0

`define ZERO_REG 5'd31            // r31 reads as zero
`define RESET_PC 64'h0            // first fetch address

// major opcodes, inst[31:26]
`define PAL_INST   6'h00
`define LDA_INST   6'h08
`define INTA_GRP   6'h10          // add, sub, compares
`define INTL_GRP   6'h11          // logicals
`define INTS_GRP   6'h12          // shifts
`define INTM_GRP   6'h13          // multiply
`define ITFP_GRP   6'h14
`define FLTV_GRP   6'h15
`define FLTI_GRP   6'h16
`define FLTL_GRP   6'h17
`define MISC_GRP   6'h18
`define JSR_GRP    6'h1a          // jmp, jsr, ret, jsr_co
`define FTPI_GRP   6'h1c
`define LDQ_INST   6'h29
`define LDQ_L_INST 6'h2b
`define STQ_INST   6'h2d
`define STQ_C_INST 6'h2f
`define BR_INST    6'h30
`define FBEQ_INST  6'h31
`define FBLT_INST  6'h32
`define FBLE_INST  6'h33
`define BSR_INST   6'h34
`define FBNE_INST  6'h35
`define FBGE_INST  6'h36
`define FBGT_INST  6'h37

////////////////////
// function codes, inst[11:5]
////////////////////
`define ADDQ_INST   7'h20
`define SUBQ_INST   7'h29
`define CMPEQ_INST  7'h2d
`define CMPULT_INST 7'h1d
`define CMPULE_INST 7'h3d
`define CMPLT_INST  7'h4d
`define CMPLE_INST  7'h6d
`define AND_INST    7'h00
`define BIC_INST    7'h08
`define BIS_INST    7'h20
`define ORNOT_INST  7'h28
`define XOR_INST    7'h40
`define EQV_INST    7'h48
`define SRL_INST    7'h34
`define SLL_INST    7'h39
`define SRA_INST    7'h3c
`define MULQ_INST   7'h20         // same code, INTM group

// pal function codes, inst[25:0]
`define PAL_HALT  26'h555
`define PAL_WHAMI 26'h3c

`endif

//--- alpha_pkg.sv
////////////////////
// shared types of the alpha front end
// widths follow the alpha format and are fixed
// id_packet_t carries the control fields without the dest select
////////////////////
package alpha_pkg;

  typedef logic [31:0] inst_t;    // raw instruction word
  typedef logic [63:0] addr_t;    // byte address
  typedef logic [63:0] word_t;    // register value
  typedef logic [4:0]  reg_idx_t; // architectural reg index

  typedef enum logic [1:0] {
    opa_is_rega,
    opa_is_mem_disp,
    opa_is_npc,
    opa_is_not3                   // ~3, word-align mask for jumps
  } alu_opa_sel_e;

  typedef enum logic [1:0] {
    opb_is_regb,
    opb_is_alu_imm,
    opb_is_br_disp
  } alu_opb_sel_e;

  typedef enum logic [1:0] {
    dest_none,
    dest_is_rega,
    dest_is_regc
  } dest_reg_sel_e;

  typedef enum logic [4:0] {
    alu_addq, alu_subq, alu_and, alu_bic, alu_bis, alu_ornot,
    alu_xor, alu_eqv, alu_srl, alu_sll, alu_sra, alu_cmpult,
    alu_cmpeq, alu_cmpule, alu_cmplt, alu_cmple, alu_mulq
  } alu_func_e;

  typedef enum logic [1:0] {
    fu_alu,
    fu_mult,
    fu_ld,                        // loads and stores
    fu_br
  } fu_name_e;

  typedef enum logic [1:0] {
    fs_idle,                      // no bus cycle
    fs_req,                       // read in flight
    fs_halted                     // sticky until reset
  } fetch_state_e;

  ////////////////////
  // decoder output
  ////////////////////
  typedef struct packed {
    alu_opa_sel_e  opa_sel;
    alu_opb_sel_e  opb_sel;
    dest_reg_sel_e dest_sel;
    alu_func_e     alu_func;
    fu_name_e      fu_name;
    logic          rd_mem;
    logic          wr_mem;
    logic          ldl_mem;
    logic          stc_mem;
    logic          cond_branch;
    logic          uncond_branch;
    logic          halt;
    logic          cpuid;
    logic          illegal;
    logic          valid_inst;
  } decode_ctl_t;

  // control as sent downstream, dest already resolved to an index
  typedef struct packed {
    alu_opa_sel_e opa_sel;
    alu_opb_sel_e opb_sel;
    alu_func_e    alu_func;
    fu_name_e     fu_name;
    logic         rd_mem;
    logic         wr_mem;
    logic         ldl_mem;
    logic         stc_mem;
    logic         cond_branch;
    logic         uncond_branch;
    logic         halt;
    logic         cpuid;
    logic         illegal;
    logic         valid_inst;
  } ex_ctl_t;

  typedef struct packed {
    inst_t inst;
    addr_t npc;                   // pc + 4
    logic  valid;
  } if_id_t;

  typedef struct packed {
    addr_t    npc;
    inst_t    inst;
    word_t    ra_value;
    word_t    rb_value;
    reg_idx_t dest_idx;           // ZERO_REG when nothing is written
    ex_ctl_t  ctl;
  } id_packet_t;

endpackage

//--- inst_decoder.sv
////////////////////
// combinational decode of one alpha word into control fields
// valid low forces a no-op with valid_inst low
// fp, misc and unknown codes set illegal, valid_inst drops with it
////////////////////
`include "alpha_defs.svh"

module inst_decoder
  import alpha_pkg::*;
(
  input  inst_t       inst,
  input  logic        valid,
  output decode_ctl_t ctl
);

  always_comb
  begin
    // no-op defaults, groups below override
    ctl.opa_sel       = opa_is_rega;
    ctl.opb_sel       = opb_is_regb;
    ctl.dest_sel      = dest_none;
    ctl.alu_func      = alu_addq;
    ctl.fu_name       = fu_alu;
    ctl.rd_mem        = `FALSE;
    ctl.wr_mem        = `FALSE;
    ctl.ldl_mem       = `FALSE;
    ctl.stc_mem       = `FALSE;
    ctl.cond_branch   = `FALSE;
    ctl.uncond_branch = `FALSE;
    ctl.halt          = `FALSE;
    ctl.cpuid         = `FALSE;
    ctl.illegal       = `FALSE;
    if (valid)
    begin
      case ({inst[31:29], 3'b000})  // opcode class, top three bits
        6'h00:
          if (inst[31:26] == `PAL_INST && inst[25:0] == `PAL_HALT)
            ctl.halt = `TRUE;
          else if (inst[31:26] == `PAL_INST && inst[25:0] == `PAL_WHAMI)
          begin
            ctl.cpuid    = `TRUE;
            ctl.dest_sel = dest_is_rega;  // cpu id lands in ra
          end
          else
            ctl.illegal = `TRUE;
        6'h10:
        begin
          // operate format, literal when bit 12 set
          ctl.opb_sel  = inst[12] ? opb_is_alu_imm : opb_is_regb;
          ctl.dest_sel = dest_is_regc;
          case (inst[31:26])
            `INTA_GRP:
              case (inst[11:5])
                `ADDQ_INST:   ctl.alu_func = alu_addq;
                `SUBQ_INST:   ctl.alu_func = alu_subq;
                `CMPEQ_INST:  ctl.alu_func = alu_cmpeq;
                `CMPULT_INST: ctl.alu_func = alu_cmpult;
                `CMPULE_INST: ctl.alu_func = alu_cmpule;
                `CMPLT_INST:  ctl.alu_func = alu_cmplt;
                `CMPLE_INST:  ctl.alu_func = alu_cmple;
                default:      ctl.illegal  = `TRUE;
              endcase
            `INTL_GRP:
              case (inst[11:5])
                `AND_INST:   ctl.alu_func = alu_and;
                `BIC_INST:   ctl.alu_func = alu_bic;
                `BIS_INST:   ctl.alu_func = alu_bis;
                `ORNOT_INST: ctl.alu_func = alu_ornot;
                `XOR_INST:   ctl.alu_func = alu_xor;
                `EQV_INST:   ctl.alu_func = alu_eqv;
                default:     ctl.illegal  = `TRUE;
              endcase
            `INTS_GRP:
              case (inst[11:5])
                `SRL_INST: ctl.alu_func = alu_srl;
                `SLL_INST: ctl.alu_func = alu_sll;
                `SRA_INST: ctl.alu_func = alu_sra;
                default:   ctl.illegal  = `TRUE;
              endcase
            `INTM_GRP:
            begin
              ctl.fu_name = fu_mult;
              if (inst[11:5] == `MULQ_INST)
                ctl.alu_func = alu_mulq;
              else
                ctl.illegal = `TRUE;
            end
            default: ctl.illegal = `TRUE;   // ITFP, FLTV, FLTI, FLTL
          endcase
        end
        6'h18:
          if (inst[31:26] == `JSR_GRP)
          begin
            // jmp, jsr, ret, jsr_co all behave alike
            ctl.fu_name       = fu_br;
            ctl.opa_sel       = opa_is_not3;
            ctl.alu_func      = alu_and;      // rb & ~3
            ctl.dest_sel      = dest_is_rega; // return address
            ctl.uncond_branch = `TRUE;
          end
          else
            ctl.illegal = `TRUE;              // MISC, FTPI and gaps
        6'h08, 6'h20, 6'h28:
        begin
          // memory format, ea = rb + disp
          ctl.opa_sel = opa_is_mem_disp;
          ctl.fu_name = fu_ld;
          case (inst[31:26])
            `LDA_INST:   ctl.dest_sel = dest_is_rega;
            `LDQ_INST:
            begin
              ctl.rd_mem   = `TRUE;
              ctl.dest_sel = dest_is_rega;
            end
            `LDQ_L_INST:
            begin
              ctl.rd_mem   = `TRUE;
              ctl.ldl_mem  = `TRUE;
              ctl.dest_sel = dest_is_rega;
            end
            `STQ_INST:   ctl.wr_mem = `TRUE;
            `STQ_C_INST:
            begin
              ctl.wr_mem   = `TRUE;
              ctl.stc_mem  = `TRUE;
              ctl.dest_sel = dest_is_rega;  // success flag
            end
            default:     ctl.illegal = `TRUE;
          endcase
        end
        6'h30, 6'h38:
        begin
          // branch format, target = npc + disp
          ctl.opa_sel = opa_is_npc;
          ctl.opb_sel = opb_is_br_disp;
          case (inst[31:26])
            `FBEQ_INST, `FBLT_INST, `FBLE_INST,
            `FBNE_INST, `FBGE_INST, `FBGT_INST:
              ctl.illegal = `TRUE;          // no fp branches
            `BR_INST, `BSR_INST:
            begin
              ctl.fu_name       = fu_br;
              ctl.dest_sel      = dest_is_rega;
              ctl.uncond_branch = `TRUE;
            end
            default: ctl.cond_branch = `TRUE;
          endcase
        end
        default: ctl.illegal = `TRUE;
      endcase
    end
    ctl.valid_inst = valid && !ctl.illegal;
  end

endmodule

//--- regfile.sv
////////////////////
// 32 x 64 register file, two read ports, one write port
// reads are combinational and see a same-cycle write
// r31 is never written and always reads zero
////////////////////
`include "alpha_defs.svh"

module regfile
  import alpha_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  input  reg_idx_t rda_idx,
  input  reg_idx_t rdb_idx,
  output word_t    rda_value,
  output word_t    rdb_value,
  input  logic     wr_en,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data
);

  word_t regs [0:31];

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_idx != `ZERO_REG)  // writes to r31 dropped
      regs[wr_idx] <= wr_data;
  end

  // zero first, then bypass, then the array
  assign rda_value = (rda_idx == `ZERO_REG)         ? '0      :
                     (wr_en && wr_idx == rda_idx)  ? wr_data :
                                                     regs[rda_idx];

  assign rdb_value = (rdb_idx == `ZERO_REG)         ? '0      :
                     (wr_en && wr_idx == rdb_idx)  ? wr_data :
                                                     regs[rdb_idx];

endmodule

//--- fetch_ctrl.sv
////////////////////
// sequential fetch, wishbone classic read-only master
// one read in flight, no new request while the IF/ID slot is full
// halt_seen comes from decode, after it fetch stops until reset
// no redirects, the pc only moves by 4
////////////////////
`include "alpha_defs.svh"

module fetch_ctrl
  import alpha_pkg::*;
(
  input  logic   clock,
  input  logic   rst_n,
  output logic   wb_cyc,
  output logic   wb_stb,
  output addr_t  wb_adr,
  input  inst_t  wb_rdata,
  input  logic   wb_ack,
  output if_id_t if_id,
  input  logic   if_id_take,
  input  logic   halt_seen,
  output logic   halted
);

  fetch_state_e state, state_nxt;
  addr_t        pc;
  logic         halt_q;      // halt latch
  logic         slot_valid;  // IF/ID occupied
  inst_t        slot_inst;
  addr_t        slot_npc;
  logic         slot_free;
  logic         stop;
  logic         ack_in;      // ack of our own request
  logic         load;

  assign slot_free = !slot_valid || if_id_take;  // empty or draining now
  assign stop      = halt_q || halt_seen;
  assign ack_in    = (state == fs_req) && wb_ack;
  assign load      = ack_in && !stop;            // word after halt is dropped

  ////////////////////
  // bus FSM
  ////////////////////
  always_comb
  begin
    state_nxt = state;
    case (state)
      fs_idle:
        if (stop)
          state_nxt = fs_halted;
        else if (slot_free)
          state_nxt = fs_req;  // cyc/stb rise next cycle
      fs_req:
        if (wb_ack)
          state_nxt = stop ? fs_halted : fs_idle;  // slot is full now
      fs_halted:
        state_nxt = fs_halted;
      default:
        state_nxt = fs_idle;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= fs_idle;
      pc         <= `RESET_PC;
      halt_q     <= 1'b0;
      slot_valid <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (ack_in)
        pc <= pc + 64'd4;
      if (halt_seen)
        halt_q <= 1'b1;    // sticky
      if (load)
        slot_valid <= 1'b1;
      else if (if_id_take)
        slot_valid <= 1'b0;
    end
  end

  // IF/ID payload, qualified by slot_valid
  always_ff @(posedge clock)
  begin
    if (load)
    begin
      slot_inst <= wb_rdata;
      slot_npc  <= pc + 64'd4;
    end
  end

  assign wb_cyc = (state == fs_req);
  assign wb_stb = (state == fs_req);   // single beat, same as cyc
  assign wb_adr = pc;                  // held until ack
  assign halted = (state == fs_halted);

  assign if_id = '{inst: slot_inst, npc: slot_npc, valid: slot_valid};

endmodule

//--- id_stage.sv
////////////////////
// decode stage, decoder plus register file plus ID/EX register
// operands are read in the take cycle and held in the packet
// id_pkt stays stable while id_valid is high and ex_ready low
////////////////////
`include "alpha_defs.svh"

module id_stage
  import alpha_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  if_id_t     if_id,
  output logic       if_id_take,
  output logic       halt_seen,
  input  logic       rf_wr_en,
  input  reg_idx_t   rf_wr_idx,
  input  word_t      rf_wr_data,
  output id_packet_t id_pkt,
  output logic       id_valid,
  input  logic       ex_ready
);

  reg_idx_t    ra_idx, rb_idx, rc_idx;
  reg_idx_t    dest_idx;
  word_t       ra_value, rb_value;
  decode_ctl_t ctl;
  id_packet_t  pkt_nxt;

  assign ra_idx = if_id.inst[25:21];
  assign rb_idx = if_id.inst[20:16];
  assign rc_idx = if_id.inst[4:0];

  inst_decoder u_dec (
    .inst  (if_id.inst),
    .valid (if_id.valid),
    .ctl   (ctl)
  );

  regfile u_rf (
    .clock     (clock),
    .rst_n     (rst_n),
    .rda_idx   (ra_idx),
    .rdb_idx   (rb_idx),
    .rda_value (ra_value),
    .rdb_value (rb_value),
    .wr_en     (rf_wr_en),
    .wr_idx    (rf_wr_idx),
    .wr_data   (rf_wr_data)
  );

  always_comb
  begin
    case (ctl.dest_sel)
      dest_is_rega: dest_idx = ra_idx;
      dest_is_regc: dest_idx = rc_idx;
      default:      dest_idx = `ZERO_REG;  // no writeback
    endcase
  end

  ////////////////////
  // packet assembly
  ////////////////////
  always_comb
  begin
    pkt_nxt.npc               = if_id.npc;
    pkt_nxt.inst              = if_id.inst;
    pkt_nxt.ra_value          = ra_value;
    pkt_nxt.rb_value          = rb_value;
    pkt_nxt.dest_idx          = dest_idx;
    pkt_nxt.ctl.opa_sel       = ctl.opa_sel;
    pkt_nxt.ctl.opb_sel       = ctl.opb_sel;
    pkt_nxt.ctl.alu_func      = ctl.alu_func;
    pkt_nxt.ctl.fu_name       = ctl.fu_name;
    pkt_nxt.ctl.rd_mem        = ctl.rd_mem;
    pkt_nxt.ctl.wr_mem        = ctl.wr_mem;
    pkt_nxt.ctl.ldl_mem       = ctl.ldl_mem;
    pkt_nxt.ctl.stc_mem       = ctl.stc_mem;
    pkt_nxt.ctl.cond_branch   = ctl.cond_branch;
    pkt_nxt.ctl.uncond_branch = ctl.uncond_branch;
    pkt_nxt.ctl.halt          = ctl.halt;
    pkt_nxt.ctl.cpuid         = ctl.cpuid;
    pkt_nxt.ctl.illegal       = ctl.illegal;
    pkt_nxt.ctl.valid_inst    = ctl.valid_inst;
  end

  // take when the output reg is empty or handing off this cycle
  assign if_id_take = if_id.valid && (!id_valid || ex_ready);
  assign halt_seen  = if_id_take && ctl.halt;  // fetch stops on this

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
      id_valid <= 1'b0;
    else if (if_id_take)
      id_valid <= 1'b1;
    else if (ex_ready)
      id_valid <= 1'b0;    // drained, nothing new
  end

  always_ff @(posedge clock)
  begin
    if (if_id_take)
      id_pkt <= pkt_nxt;   // otherwise held under stall
  end

endmodule

//--- front_end_top.sv
////////////////////
// front end top, fetch and decode joined by the IF/ID link
// register write port stands in for writeback
////////////////////
module front_end_top
  import alpha_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  // wishbone master, read only
  output logic       wb_cyc,
  output logic       wb_stb,
  output addr_t      wb_adr,
  input  inst_t      wb_rdata,
  input  logic       wb_ack,
  // register write port
  input  logic       rf_wr_en,
  input  reg_idx_t   rf_wr_idx,
  input  word_t      rf_wr_data,
  // decoded packet out
  output id_packet_t id_pkt,
  output logic       id_valid,
  input  logic       ex_ready,
  output logic       halted
);

  if_id_t if_id;
  logic   if_id_take;
  logic   halt_seen;

  fetch_ctrl u_fetch (
    .clock      (clock),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .if_id      (if_id),
    .if_id_take (if_id_take),
    .halt_seen  (halt_seen),
    .halted     (halted)
  );

  id_stage u_id (
    .clock      (clock),
    .rst_n      (rst_n),
    .if_id      (if_id),
    .if_id_take (if_id_take),
    .halt_seen  (halt_seen),
    .rf_wr_en   (rf_wr_en),
    .rf_wr_idx  (rf_wr_idx),
    .rf_wr_data (rf_wr_data),
    .id_pkt     (id_pkt),
    .id_valid   (id_valid),
    .ex_ready   (ex_ready)
  );

endmodule

//--- front_end_assert.sv
////////////////////
// concurrent checks on front_end_top, attached by bind
// bus and stall checks are off while rst_n is low
// n_fail counts failed assertions
////////////////////
module front_end_assert
  import alpha_pkg::*;
(
  input logic       clock,
  input logic       rst_n,
  input logic       wb_cyc,
  input logic       wb_stb,
  input addr_t      wb_adr,
  input logic       wb_ack,
  input id_packet_t id_pkt,
  input logic       id_valid,
  input logic       ex_ready,
  input logic       halted
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned n_fail = 0;

  // classic read, request and address held until ack
  a_wb_hold: assert property (@(posedge clock) disable iff (!rst_n)
    (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
  else
  begin
    n_fail++;
    $error("wishbone request dropped or address moved before ack");
  end

  // stalled packet must not change
  a_pkt_hold: assert property (@(posedge clock) disable iff (!rst_n)
    (id_valid && !ex_ready) |=> (id_valid && $stable(id_pkt)))
  else
  begin
    n_fail++;
    $error("id_pkt changed or dropped under stall");
  end

  // halt packet downstream means fetch has already stopped
  a_no_cyc_halted: assert property (@(posedge clock) disable iff (!rst_n)
    (id_valid && id_pkt.ctl.halt) |-> (halted && !wb_cyc))
  else
  begin
    n_fail++;
    $error("bus cycle or no halted while the halt packet is out");
  end

  // outputs low once reset has been seen on a clock
  a_reset_quiet: assert property (@(posedge clock)
    !rst_n |=> (!wb_cyc && !wb_stb && !id_valid && !halted))
  else
  begin
    n_fail++;
    $error("control output active during reset");
  end

endmodule

//--- tb_front_end.sv
////////////////////
// testbench for front_end_top
// 200 random words with the only halt at word 180
// 0 to 3 wait states per read, ex_ready high about 70% of cycles
// first ack held back until all registers are preloaded
////////////////////
`include "alpha_defs.svh"

module tb_front_end
  import alpha_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS   = 200;
  localparam int HALT_WORD   = 180;
  localparam int N_TESTS     = 5;
  localparam int T_DECODE    = 0;
  localparam int T_OPERANDS  = 1;
  localparam int T_ORDER     = 2;
  localparam int T_ILLEGAL   = 3;
  localparam int T_HALT      = 4;
  localparam int WATCHDOG_NS = MEM_WORDS * 5 * 20 + 4000;  // 5 cycles per word plus margin

  logic       clock;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  addr_t      wb_adr;
  inst_t      wb_rdata;
  logic       wb_ack;
  logic       rf_wr_en;
  reg_idx_t   rf_wr_idx;
  word_t      rf_wr_data;
  id_packet_t id_pkt;
  logic       id_valid;
  logic       ex_ready;
  logic       halted;

  integer seed = 32'ha4df_4d03;
  inst_t  mem [MEM_WORDS];        // program image
  word_t  ref_regs [32];          // model register file
  logic   preload_done;
  int     wait_left;              // wait states before next ack
  int     n_acc;                  // accepted packets
  logic   halt_taken;             // halt packet went downstream
  logic   cyc_after_halt;
  int     n_chk [N_TESTS];
  int     n_err [N_TESTS];
  string  tname [N_TESTS] = '{"decode", "operands", "order", "illegal", "halt"};

  // function codes mixed over all four operate groups, 7f is never legal
  logic [6:0] fn_tab [16] = '{`ADDQ_INST, `SUBQ_INST, `CMPEQ_INST, `CMPULT_INST,
                              `CMPULE_INST, `CMPLT_INST, `CMPLE_INST, `AND_INST,
                              `BIC_INST, `ORNOT_INST, `XOR_INST, `EQV_INST,
                              `SRL_INST, `SLL_INST, `SRA_INST, 7'h7f};
  logic [5:0] mem_tab [5]  = '{`LDA_INST, `LDQ_INST, `LDQ_L_INST, `STQ_INST, `STQ_C_INST};

  front_end_top u_dut (
    .clock      (clock),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .rf_wr_en   (rf_wr_en),
    .rf_wr_idx  (rf_wr_idx),
    .rf_wr_data (rf_wr_data),
    .id_pkt     (id_pkt),
    .id_valid   (id_valid),
    .ex_ready   (ex_ready),
    .halted     (halted)
  );

  bind front_end_top front_end_assert u_assert (.*);

  always #10 clock = ~clock;  // 20 ns period

  ////////////////////
  // reference model
  ////////////////////
  // legal operate pairs, op and function together
  function automatic logic lookup_alu(input logic [5:0] op, input logic [6:0] fn,
                                      output alu_func_e f);
    f = alu_addq;
    lookup_alu = 1'b1;
    case ({op, fn})
      {`INTA_GRP, `ADDQ_INST}:   f = alu_addq;
      {`INTA_GRP, `SUBQ_INST}:   f = alu_subq;
      {`INTA_GRP, `CMPEQ_INST}:  f = alu_cmpeq;
      {`INTA_GRP, `CMPULT_INST}: f = alu_cmpult;
      {`INTA_GRP, `CMPULE_INST}: f = alu_cmpule;
      {`INTA_GRP, `CMPLT_INST}:  f = alu_cmplt;
      {`INTA_GRP, `CMPLE_INST}:  f = alu_cmple;
      {`INTL_GRP, `AND_INST}:    f = alu_and;
      {`INTL_GRP, `BIC_INST}:    f = alu_bic;
      {`INTL_GRP, `BIS_INST}:    f = alu_bis;
      {`INTL_GRP, `ORNOT_INST}:  f = alu_ornot;
      {`INTL_GRP, `XOR_INST}:    f = alu_xor;
      {`INTL_GRP, `EQV_INST}:    f = alu_eqv;
      {`INTS_GRP, `SRL_INST}:    f = alu_srl;
      {`INTS_GRP, `SLL_INST}:    f = alu_sll;
      {`INTS_GRP, `SRA_INST}:    f = alu_sra;
      {`INTM_GRP, `MULQ_INST}:   f = alu_mulq;
      default:                   lookup_alu = 1'b0;
    endcase
  endfunction

  function automatic ex_ctl_t ref_decode(input inst_t w, output reg_idx_t dest);
    ex_ctl_t   c;
    alu_func_e f;
    c    = '0;                     // all enums start at their first value
    dest = `ZERO_REG;
    case (w[31:26])
      `PAL_INST:
        if (w[25:0] == `PAL_HALT)
          c.halt = 1'b1;
        else if (w[25:0] == `PAL_WHAMI)
        begin
          c.cpuid = 1'b1;
          dest    = w[25:21];
        end
        else
          c.illegal = 1'b1;
      `INTA_GRP, `INTL_GRP, `INTS_GRP, `INTM_GRP:
      begin
        c.opb_sel  = w[12] ? opb_is_alu_imm : opb_is_regb;  // literal form
        c.illegal  = !lookup_alu(w[31:26], w[11:5], f);
        c.alu_func = f;
        c.fu_name  = (w[31:26] == `INTM_GRP) ? fu_mult : fu_alu;
        dest       = w[4:0];
      end
      `JSR_GRP:
      begin
        c.fu_name       = fu_br;
        c.opa_sel       = opa_is_not3;
        c.alu_func      = alu_and;
        c.uncond_branch = 1'b1;
        dest            = w[25:21];
      end
      `LDA_INST, `LDQ_INST, `LDQ_L_INST, `STQ_INST, `STQ_C_INST:
      begin
        c.opa_sel = opa_is_mem_disp;
        c.fu_name = fu_ld;
        c.rd_mem  = (w[31:26] == `LDQ_INST) || (w[31:26] == `LDQ_L_INST);
        c.ldl_mem = (w[31:26] == `LDQ_L_INST);
        c.wr_mem  = (w[31:26] == `STQ_INST) || (w[31:26] == `STQ_C_INST);
        c.stc_mem = (w[31:26] == `STQ_C_INST);
        if (w[31:26] != `STQ_INST)
          dest = w[25:21];         // loads, lda, stq_c flag
      end
      `BR_INST, `BSR_INST:
      begin
        c.opa_sel       = opa_is_npc;
        c.opb_sel       = opb_is_br_disp;
        c.fu_name       = fu_br;
        c.uncond_branch = 1'b1;
        dest            = w[25:21];  // link register
      end
      default:
        if (w[31:26] >= 6'h38)
        begin
          c.opa_sel     = opa_is_npc;  // integer conditional branches
          c.opb_sel     = opb_is_br_disp;
          c.cond_branch = 1'b1;
        end
        else
          c.illegal = 1'b1;
    endcase
    c.valid_inst = !c.illegal;
    return c;
  endfunction

  // other fields of an illegal word carry no meaning
  function automatic ex_ctl_t illegal_flags(input ex_ctl_t c);
    ex_ctl_t m;
    m            = '0;
    m.illegal    = c.illegal;
    m.valid_inst = c.valid_inst;
    return m;
  endfunction

  function automatic inst_t mem_read(input addr_t a);
    if (a[63:2] < MEM_WORDS)
      return mem[a[63:2]];
    return '0;                     // pal 0, illegal
  endfunction

  ////////////////////
  // checks
  ////////////////////
  task automatic check_ctl(input int t, input ex_ctl_t exp, input ex_ctl_t act);
    n_chk[t]++;
    if (exp !== act)
    begin
      n_err[t]++;
      $display("FAILED %s expected %h actual %h (packet %0d)", tname[t], exp, act, n_acc);
    end
  endtask

  task automatic check_word(input int t, input word_t exp, input word_t act);
    n_chk[t]++;
    if (exp !== act)
    begin
      n_err[t]++;
      $display("FAILED %s expected %h actual %h (packet %0d)", tname[t], exp, act, n_acc);
    end
  endtask

  task automatic check_inst(input int t, input inst_t exp, input inst_t act);
    n_chk[t]++;
    if (exp !== act)
    begin
      n_err[t]++;
      $display("FAILED %s expected %h actual %h (packet %0d)", tname[t], exp, act, n_acc);
    end
  endtask

  task automatic check_idx(input int t, input reg_idx_t exp, input reg_idx_t act);
    n_chk[t]++;
    if (exp !== act)
    begin
      n_err[t]++;
      $display("FAILED %s expected %0d actual %0d (packet %0d)", tname[t], exp, act, n_acc);
    end
  endtask

  task automatic check_addr(input int t, input addr_t exp, input addr_t act);
    n_chk[t]++;
    if (exp !== act)
    begin
      n_err[t]++;
      $display("FAILED %s expected %h actual %h (packet %0d)", tname[t], exp, act, n_acc);
    end
  endtask

  task automatic report_fail(input int t, input string msg);
    n_err[t]++;
    $display("error in %s test: %s", tname[t], msg);
  endtask

  task automatic build_program();
    inst_t w;
    int    k;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      k = {$random(seed)} % 10;
      w = $random(seed);           // register fields and payload
      case (k)
        0, 1, 2, 3:
        begin
          w[31:26] = 6'h10 + ({$random(seed)} % 4);  // operate groups
          w[11:5]  = fn_tab[{$random(seed)} % 16];
        end
        4, 5:    w[31:26] = mem_tab[{$random(seed)} % 5];
        6:       w[31:26] = 6'h30 + ({$random(seed)} % 16);  // br, fb*, bsr, cond
        7:       w[31:26] = `JSR_GRP;
        8:
        begin
          w[31:26] = `PAL_INST;
          w[25]    = 1'b1;         // never halt or whami
          if (w[0])
            w[25:0] = `PAL_WHAMI;
        end
        default: w[31:26] = 6'd1 + ({$random(seed)} % 63);  // any non-pal opcode
      endcase
      mem[i] = w;
    end
    mem[HALT_WORD] = {`PAL_INST, `PAL_HALT};
  endtask

  ////////////////////
  // memory, back-pressure and packet monitor
  ////////////////////
  always @(posedge clock)
  begin : bus_side
    ex_ctl_t  exp_ctl;
    reg_idx_t exp_dest;
    inst_t    w;
    if (preload_done)
    begin
      ex_ready <= ({$random(seed)} % 10) < 7;
      if (wb_ack)
        wb_ack <= 1'b0;            // one ack per read
      else if (wb_cyc && wb_stb)
      begin
        if (wait_left == 0)
        begin
          wb_ack    <= 1'b1;
          wb_rdata  <= mem_read(wb_adr);
          wait_left = {$random(seed)} % 4;
        end
        else
          wait_left--;
      end
    end
    if ((halted || halt_taken) && wb_cyc && !cyc_after_halt)
    begin
      cyc_after_halt = 1'b1;
      report_fail(T_HALT, "wb_cyc raised after the halt");
    end
    if (id_valid && ex_ready)      // transfer on this edge
    begin
      check_addr(T_ORDER, addr_t'(n_acc + 1) << 2, id_pkt.npc);
      w       = (n_acc < MEM_WORDS) ? mem[n_acc] : '0;
      exp_ctl = ref_decode(w, exp_dest);
      check_inst(T_DECODE, w, id_pkt.inst);
      if (exp_ctl.illegal)
        check_ctl(T_ILLEGAL, illegal_flags(exp_ctl), illegal_flags(id_pkt.ctl));
      else
      begin
        check_ctl(T_DECODE, exp_ctl, id_pkt.ctl);
        check_idx(T_DECODE, exp_dest, id_pkt.dest_idx);
      end
      check_word(T_OPERANDS, ref_regs[w[25:21]], id_pkt.ra_value);
      check_word(T_OPERANDS, ref_regs[w[20:16]], id_pkt.rb_value);
      if (id_pkt.ctl.halt)
        halt_taken = 1'b1;
      n_acc++;
    end
  end

  ////////////////////
  // main sequence
  ////////////////////
  initial
  begin : main_seq
    word_t val;
    int    total_chk;
    int    total_err;
    int    n_assert;
    clock          = 1'b0;
    rst_n          = 1'b0;
    wb_rdata       = '0;
    wb_ack         = 1'b0;
    rf_wr_en       = 1'b0;
    rf_wr_idx      = '0;
    rf_wr_data     = '0;
    ex_ready       = 1'b0;
    preload_done   = 1'b0;
    wait_left      = 0;
    n_acc          = 0;
    halt_taken     = 1'b0;
    cyc_after_halt = 1'b0;
    for (int t = 0; t < N_TESTS; t++)
    begin
      n_chk[t] = 0;
      n_err[t] = 0;
    end
    build_program();
    repeat (10) @(posedge clock);
    rst_n <= 1'b1;
    // preload all registers, r31 too so the ignored write shows
    for (int i = 0; i < 32; i++)
    begin
      @(posedge clock);
      val = {$random(seed), $random(seed)};
      rf_wr_en    <= 1'b1;
      rf_wr_idx   <= reg_idx_t'(i);
      rf_wr_data  <= val;
      ref_regs[i] = (i == 31) ? '0 : val;
    end
    @(posedge clock);
    rf_wr_en     <= 1'b0;
    preload_done <= 1'b1;
    while (!(halted && n_acc >= HALT_WORD + 1))
      @(negedge clock);
    repeat (20) @(negedge clock);  // stray packets or bus cycles show up here
    n_chk[T_HALT]++;
    if (n_acc != HALT_WORD + 1)
      report_fail(T_HALT, $sformatf("%0d packets accepted, %0d expected", n_acc, HALT_WORD + 1));
    total_chk = 0;
    total_err = 0;
    for (int t = 0; t < N_TESTS; t++)
    begin
      $display("test %-8s : %0d checks, %0d errors", tname[t], n_chk[t], n_err[t]);
      total_chk += n_chk[t];
      total_err += n_err[t];
    end
    n_assert = u_dut.u_assert.n_fail;
    $display("total: %0d checks, %0d errors, %0d assertion failures, %0d packets",
             total_chk, total_err, n_assert, n_acc);
    if (total_err == 0 && n_assert == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog, sized from the program length
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: halt not reached after %0d ns, %0d packets accepted", WATCHDOG_NS, n_acc);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
alpha_pkg.sv
inst_decoder.sv
regfile.sv
fetch_ctrl.sv
id_stage.sv
front_end_top.sv
front_end_assert.sv
tb_front_end.sv

//--- Bender.yml
package:
  name: alpha_front_end

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - alpha_pkg.sv
      - inst_decoder.sv
      - regfile.sv
      - fetch_ctrl.sv
      - id_stage.sv
      - front_end_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - front_end_assert.sv
      - tb_front_end.sv
